// ==== logic/cordic_pkg.sv ====
package cordic_pkg;

    // word format
    localparam int DATA_W     = 32;  // Q16.16 words
    localparam int FRAC_BITS  = 16;
    localparam int ITERATIONS = 16;  // one micro-rotation per clock
    localparam int ITER_W     = 4;

    typedef logic signed [DATA_W-1:0] data_t;

    localparam logic [ITER_W-1:0] LAST_ITER = ITER_W'(ITERATIONS - 1);

    // 1/K for 16 circular iterations, 0.60725 * 2^16
    localparam data_t K_INV_CIRCULAR = 32'sd39797;

    // angle thresholds in Q16.16
    localparam data_t QUARTER_PI_Q       = 32'sd51472;   // pi/4
    localparam data_t HALF_PI_Q          = 32'sd102944;  // pi/2
    localparam data_t THREE_QUARTER_PI_Q = 32'sd154416;  // 3pi/4
    localparam data_t PI_Q               = 32'sd205887;  // pi
    localparam data_t FIVE_QUARTER_PI_Q  = 32'sd257359;  // 5pi/4
    localparam data_t SEVEN_QUARTER_PI_Q = 32'sd360303;  // 7pi/4
    localparam data_t TWO_PI_Q           = 32'sd411775;  // 2pi

    typedef enum logic {
        op_rotate = 1'b0,  // cos/sin of z_in
        op_vector = 1'b1   // magnitude and angle of (x_in, y_in)
    } op_t;

    // octant pair the reduced angle came from
    typedef enum logic [1:0] {
        quad_front = 2'd0,  // (-pi/4, pi/4]
        quad_up    = 2'd1,  // (pi/4, 3pi/4]
        quad_back  = 2'd2,  // (3pi/4, 5pi/4]
        quad_down  = 2'd3   // (5pi/4, 7pi/4]
    } quadrant_t;

    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_reduce  = 2'd1,
        st_iterate = 2'd2,
        st_finish  = 2'd3
    } ctrl_state_t;

    typedef enum logic [1:0] {
        rd_idle = 2'd0,
        rd_wrap = 2'd1,
        rd_fold = 2'd2
    } reduce_state_t;

endpackage

// ==== logic/cordic_ctrl.sv ====
`timescale 1ns/1ps

module cordic_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            enable,
    input  cordic_pkg::op_t                 op,
    input  logic                            reduce_done,
    output logic                            reduce_start,
    output logic                            load,
    output logic                            step,
    output logic [cordic_pkg::ITER_W-1:0]   iter_idx,
    output logic                            finish,
    output cordic_pkg::op_t                 op_q,
    output logic                            valid
);

    cordic_pkg::ctrl_state_t state;

    // sequencing FSM, enable only counts in idle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= cordic_pkg::st_idle;
            op_q     <= cordic_pkg::op_rotate;
            load     <= 1'b0;
            iter_idx <= '0;
            valid    <= 1'b0;
        end else begin
            load  <= 1'b0;                                // single-cycle strobe
            valid <= (state == cordic_pkg::st_finish);    // outputs land with valid
            case (state)
                cordic_pkg::st_idle: begin
                    iter_idx <= '0;
                    if (enable) begin
                        op_q <= op;
                        if (op == cordic_pkg::op_vector) begin
                            state <= cordic_pkg::st_iterate;
                            load  <= 1'b1;                // vectoring needs no reduction
                        end else begin
                            state <= cordic_pkg::st_reduce;
                        end
                    end
                end
                cordic_pkg::st_reduce: begin
                    if (reduce_done) begin
                        state <= cordic_pkg::st_iterate;
                        load  <= 1'b1;                    // z_base is settled by now
                    end
                end
                cordic_pkg::st_iterate: begin
                    if (step) begin
                        if (iter_idx == cordic_pkg::LAST_ITER) begin
                            state    <= cordic_pkg::st_finish;
                            iter_idx <= '0;
                        end else begin
                            iter_idx <= iter_idx + 1'b1;
                        end
                    end
                end
                cordic_pkg::st_finish: begin
                    state <= cordic_pkg::st_idle;
                end
                default: begin
                    state <= cordic_pkg::st_idle;
                end
            endcase
        end
    end

    // reducer samples z_in on the same edge that takes enable
    assign reduce_start = (state == cordic_pkg::st_idle) && enable &&
                          (op == cordic_pkg::op_rotate);

    // first cycle in st_iterate is spent on the load
    assign step   = (state == cordic_pkg::st_iterate) && !load;
    assign finish = (state == cordic_pkg::st_finish);

endmodule

// ==== logic/angle_reducer.sv ====
`timescale 1ns/1ps

module angle_reducer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  reduce_start,
    input  cordic_pkg::data_t     z_in,
    output cordic_pkg::data_t     z_base,
    output cordic_pkg::quadrant_t quad,
    output logic                  reduce_done
);

    cordic_pkg::reduce_state_t state;
    cordic_pkg::data_t         z_work;   // angle being wrapped
    logic                      too_high;
    logic                      too_low;

    assign too_high = (z_work > cordic_pkg::TWO_PI_Q);
    assign too_low  = (z_work < -cordic_pkg::QUARTER_PI_Q);

    // one 2pi step per cycle until the angle sits in (-pi/4, 2pi]
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cordic_pkg::rd_idle;
        end else begin
            case (state)
                cordic_pkg::rd_idle: begin
                    if (reduce_start) begin
                        state <= cordic_pkg::rd_wrap;
                    end
                end
                cordic_pkg::rd_wrap: begin
                    if (!too_high && !too_low) begin
                        state <= cordic_pkg::rd_fold;
                    end
                end
                cordic_pkg::rd_fold: begin
                    state <= cordic_pkg::rd_idle;
                end
                default: begin
                    state <= cordic_pkg::rd_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            cordic_pkg::rd_idle: begin
                if (reduce_start) begin
                    z_work <= z_in;
                end
            end
            cordic_pkg::rd_wrap: begin
                if (too_high) begin
                    z_work <= z_work - cordic_pkg::TWO_PI_Q;
                end else if (too_low) begin
                    z_work <= z_work + cordic_pkg::TWO_PI_Q;
                end else if (z_work > cordic_pkg::SEVEN_QUARTER_PI_Q) begin
                    z_work <= z_work - cordic_pkg::TWO_PI_Q;  // (7pi/4, 2pi] belongs to front
                end
            end
            cordic_pkg::rd_fold: begin
                // z_work is now in (-pi/4, 7pi/4]
                if (z_work <= cordic_pkg::QUARTER_PI_Q) begin
                    quad   <= cordic_pkg::quad_front;
                    z_base <= z_work;
                end else if (z_work <= cordic_pkg::THREE_QUARTER_PI_Q) begin
                    quad   <= cordic_pkg::quad_up;
                    z_base <= z_work - cordic_pkg::HALF_PI_Q;
                end else if (z_work <= cordic_pkg::FIVE_QUARTER_PI_Q) begin
                    quad   <= cordic_pkg::quad_back;
                    z_base <= z_work - cordic_pkg::PI_Q;
                end else begin
                    quad   <= cordic_pkg::quad_down;
                    z_base <= z_work - cordic_pkg::PI_Q - cordic_pkg::HALF_PI_Q;  // 3pi/2
                end
            end
            default: begin
                z_work <= z_work;
            end
        endcase
    end

    // fold results are registered at the end of this cycle, before load is sampled
    assign reduce_done = (state == cordic_pkg::rd_fold);

endmodule

// ==== logic/cordic_iter.sv ====
`timescale 1ns/1ps

module cordic_iter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load,
    input  logic                          step,
    input  logic [cordic_pkg::ITER_W-1:0] iter_idx,
    input  cordic_pkg::op_t               op,
    input  cordic_pkg::data_t             x_in,
    input  cordic_pkg::data_t             y_in,
    input  cordic_pkg::data_t             z_in,
    input  cordic_pkg::data_t             z_base,
    output cordic_pkg::data_t             x_cur,
    output cordic_pkg::data_t             y_cur,
    output cordic_pkg::data_t             z_cur
);

    cordic_pkg::data_t x_sh;
    cordic_pkg::data_t y_sh;
    cordic_pkg::data_t alpha;
    logic              dir_pos;  // rotate counter-clockwise

    // atan(2^-i) in Q16.16
    function automatic cordic_pkg::data_t atan_lut(input logic [cordic_pkg::ITER_W-1:0] idx);
        case (idx)
            4'd0:    atan_lut = 32'sd51472;
            4'd1:    atan_lut = 32'sd30386;
            4'd2:    atan_lut = 32'sd16055;
            4'd3:    atan_lut = 32'sd8150;
            4'd4:    atan_lut = 32'sd4091;
            4'd5:    atan_lut = 32'sd2047;
            4'd6:    atan_lut = 32'sd1024;
            4'd7:    atan_lut = 32'sd512;
            4'd8:    atan_lut = 32'sd256;
            4'd9:    atan_lut = 32'sd128;
            4'd10:   atan_lut = 32'sd64;
            4'd11:   atan_lut = 32'sd32;
            4'd12:   atan_lut = 32'sd16;
            4'd13:   atan_lut = 32'sd8;
            4'd14:   atan_lut = 32'sd4;
            default: atan_lut = 32'sd2;  // index 15
        endcase
    endfunction

    assign x_sh  = x_cur >>> iter_idx;   // arithmetic, keeps sign
    assign y_sh  = y_cur >>> iter_idx;
    assign alpha = atan_lut(iter_idx);

    always_comb begin
        if (op == cordic_pkg::op_rotate) begin
            dir_pos = ~z_cur[cordic_pkg::DATA_W-1];  // drive z toward zero
        end else begin
            dir_pos = x_cur[cordic_pkg::DATA_W-1] ^ y_cur[cordic_pkg::DATA_W-1];  // drive y toward zero
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x_cur <= '0;
            y_cur <= '0;
            z_cur <= '0;
        end else if (load) begin
            if (op == cordic_pkg::op_rotate) begin
                x_cur <= cordic_pkg::K_INV_CIRCULAR;  // pre-scaled so the result needs no gain fix
                y_cur <= y_in;
                z_cur <= z_base;
            end else begin
                x_cur <= x_in;
                y_cur <= y_in;
                z_cur <= z_in;
            end
        end else if (step) begin
            x_cur <= dir_pos ? (x_cur - y_sh)  : (x_cur + y_sh);
            y_cur <= dir_pos ? (y_cur + x_sh)  : (y_cur - x_sh);
            z_cur <= dir_pos ? (z_cur - alpha) : (z_cur + alpha);
        end
    end

endmodule

// ==== logic/result_fix.sv ====
`timescale 1ns/1ps

module result_fix (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  finish,
    input  cordic_pkg::op_t       op,
    input  cordic_pkg::quadrant_t quad,
    input  cordic_pkg::data_t     x_cur,
    input  cordic_pkg::data_t     y_cur,
    input  cordic_pkg::data_t     z_cur,
    output cordic_pkg::data_t     x_out,
    output cordic_pkg::data_t     y_out,
    output cordic_pkg::data_t     z_out
);

    cordic_pkg::data_t                     x_abs;
    logic signed [2*cordic_pkg::DATA_W-1:0] gain_prod;  // Q32.32

    assign x_abs     = x_cur[cordic_pkg::DATA_W-1] ? -x_cur : x_cur;
    assign gain_prod = x_abs * cordic_pkg::K_INV_CIRCULAR;

    // outputs hold until the next finish
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x_out <= '0;
            y_out <= '0;
            z_out <= '0;
        end else if (finish) begin
            if (op == cordic_pkg::op_vector) begin
                x_out <= gain_prod[cordic_pkg::FRAC_BITS +: cordic_pkg::DATA_W];  // back to Q16.16
                y_out <= y_cur;
            end else begin
                case (quad)
                    cordic_pkg::quad_up: begin    // +pi/2
                        x_out <= -y_cur;
                        y_out <= x_cur;
                    end
                    cordic_pkg::quad_back: begin  // +pi
                        x_out <= -x_cur;
                        y_out <= -y_cur;
                    end
                    cordic_pkg::quad_down: begin  // +3pi/2
                        x_out <= y_cur;
                        y_out <= -x_cur;
                    end
                    default: begin
                        x_out <= x_cur;
                        y_out <= y_cur;
                    end
                endcase
            end
            z_out <= z_cur;  // residual angle in rotation
        end
    end

endmodule

// ==== logic/cordic_top.sv ====
`timescale 1ns/1ps

module cordic_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              enable,
    input  cordic_pkg::op_t   op,
    input  cordic_pkg::data_t x_in,
    input  cordic_pkg::data_t y_in,
    input  cordic_pkg::data_t z_in,
    output cordic_pkg::data_t x_out,
    output cordic_pkg::data_t y_out,
    output cordic_pkg::data_t z_out,
    output logic              valid
);

    logic                          reduce_start;
    logic                          reduce_done;
    logic                          load;
    logic                          step;
    logic                          finish;
    logic [cordic_pkg::ITER_W-1:0] iter_idx;
    cordic_pkg::op_t               op_q;
    cordic_pkg::data_t             z_base;
    cordic_pkg::quadrant_t         quad;
    cordic_pkg::data_t             x_cur;
    cordic_pkg::data_t             y_cur;
    cordic_pkg::data_t             z_cur;

    cordic_ctrl i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .op           (op),
        .reduce_done  (reduce_done),
        .reduce_start (reduce_start),
        .load         (load),
        .step         (step),
        .iter_idx     (iter_idx),
        .finish       (finish),
        .op_q         (op_q),
        .valid        (valid)
    );

    angle_reducer i_reducer (
        .clk          (clk),
        .rst          (rst),
        .reduce_start (reduce_start),
        .z_in         (z_in),
        .z_base       (z_base),
        .quad         (quad),
        .reduce_done  (reduce_done)
    );

    cordic_iter i_iter (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .step     (step),
        .iter_idx (iter_idx),
        .op       (op_q),
        .x_in     (x_in),
        .y_in     (y_in),
        .z_in     (z_in),
        .z_base   (z_base),
        .x_cur    (x_cur),
        .y_cur    (y_cur),
        .z_cur    (z_cur)
    );

    result_fix i_fix (
        .clk    (clk),
        .rst    (rst),
        .finish (finish),
        .op     (op_q),
        .quad   (quad),
        .x_cur  (x_cur),
        .y_cur  (y_cur),
        .z_cur  (z_cur),
        .x_out  (x_out),
        .y_out  (y_out),
        .z_out  (z_out)
    );

endmodule

// ==== test/cordic_sva.sv ====
`timescale 1ns/1ps

module cordic_sva (
    input logic            clk,
    input logic            rst,
    input logic            enable,
    input cordic_pkg::op_t op,
    input logic            valid
);

    logic pending;  // accepted enable still waiting for its valid
    logic accept;
    int   fail_count = 0;  // failed assertions so far

    // the engine is idle again in the cycle valid is high
    assign accept = enable && (!pending || valid);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (valid) begin
            pending <= 1'b0;
        end
    end

    valid_single_cycle: assert property (@(posedge clk) disable iff (rst) valid |=> !valid)
        else begin
            $error("valid stayed high for more than one cycle");
            fail_count++;
        end

    valid_needs_enable: assert property (@(posedge clk) disable iff (rst) valid |-> pending)
        else begin
            $error("valid without an outstanding enable");
            fail_count++;
        end

    vector_latency: assert property (@(posedge clk) disable iff (rst)
        accept && op == cordic_pkg::op_vector |-> ##19 valid)
        else begin
            $error("vectoring valid not 19 cycles after enable");
            fail_count++;
        end

endmodule

bind cordic_top cordic_sva i_sva (
    .clk    (clk),
    .rst    (rst),
    .enable (enable),
    .op     (op),
    .valid  (valid)
);

// ==== test/tb_cordic.sv ====
`timescale 1ns/1ps

module tb_cordic;

    localparam int  TOL           = 64;  // LSB distance accepted against the real model
    localparam int  VALID_TIMEOUT = 200;
    localparam real SCALE         = 65536.0;
    localparam real PI            = 3.14159265358979;

    logic              clk;
    logic              rst;
    logic              enable;
    cordic_pkg::op_t   op;
    cordic_pkg::data_t x_in;
    cordic_pkg::data_t y_in;
    cordic_pkg::data_t z_in;
    cordic_pkg::data_t x_out;
    cordic_pkg::data_t y_out;
    cordic_pkg::data_t z_out;
    logic              valid;

    logic [31:0] lfsr;
    int          checks;
    int          errors;
    int          tests;
    int          latency;

    cordic_top i_cordic_top (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .op     (op),
        .x_in   (x_in),
        .y_in   (y_in),
        .z_in   (z_in),
        .x_out  (x_out),
        .y_out  (y_out),
        .z_out  (z_out),
        .valid  (valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'hA300_0000;  // x^32 + x^30 + x^26 + x^25 + 1
        end
        return n;
    endfunction

    function automatic int take_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_next(lfsr);  // one step per bit
        end
        return value;
    endfunction

    // folded quadrant 0..3 for a real angle, front/up/back/down
    function automatic int quadrant_of(input real ang);
        real a;
        a = ang;
        while (a > 1.75 * PI) begin
            a = a - 2.0 * PI;
        end
        while (a <= -0.25 * PI) begin
            a = a + 2.0 * PI;
        end
        return int'($ceil((a + 0.25 * PI) / (0.5 * PI))) - 1;
    endfunction

    task automatic check_flag(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("%s", msg);
            errors++;
        end
    endtask

    task automatic check_near(input string what, input cordic_pkg::data_t got, input real expv);
        real diff;
        diff = $itor(got) - expv;
        check_flag(diff <= TOL && diff >= -TOL,
                   $sformatf("error at %0t: %s is %0d, expected %0.1f", $time, what, got, expv));
    endtask

    task automatic finish_test(input string name, input int err0);
        tests++;
        $display("test %s finished with %0d failed checks", name, errors - err0);
    endtask

    task automatic start_op(input cordic_pkg::op_t o, input cordic_pkg::data_t x,
                            input cordic_pkg::data_t y, input cordic_pkg::data_t z);
        @(negedge clk);
        op     = o;
        x_in   = x;
        y_in   = y;
        z_in   = z;
        enable = 1'b1;
        @(negedge clk);
        enable = 1'b0;
    endtask

    // cycles counted in falling edges from the one that raised enable
    task automatic wait_valid(output int cycles);
        cycles = 1;
        while (!valid && cycles <= VALID_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        check_flag(valid, $sformatf("valid never came within %0d cycles", VALID_TIMEOUT));
    endtask

    task automatic run_rotation(input cordic_pkg::data_t z);
        real ang;
        ang = $itor(z) / SCALE;
        start_op(cordic_pkg::op_rotate, '0, '0, z);  // y_in must be zero for cos/sin
        wait_valid(latency);
        check_near("cos", x_out, $cos(ang) * SCALE);
        check_near("sin", y_out, $sin(ang) * SCALE);
    endtask

    task automatic run_vectoring(input cordic_pkg::data_t x, input cordic_pkg::data_t y);
        real xr;
        real yr;
        xr = $itor(x) / SCALE;
        yr = $itor(y) / SCALE;
        start_op(cordic_pkg::op_vector, x, y, '0);
        wait_valid(latency);
        check_flag(latency == 19,
                   $sformatf("error at %0t: vectoring latency %0d, expected 19", $time, latency));
        check_near("magnitude", x_out, $sqrt(xr * xr + yr * yr) * SCALE);
        check_near("residual y", y_out, 0.0);
        check_near("angle", z_out, $atan2(yr, xr) * SCALE);
    endtask

    task automatic test_reset_idle();
        int err0;
        err0 = errors;
        repeat (20) begin
            @(negedge clk);
            check_flag(!valid, "valid went high although no operation was started");
        end
        finish_test("reset_idle", err0);
    endtask

    task automatic test_rotate_base();
        cordic_pkg::data_t angles[5];
        int                err0;
        err0   = errors;
        angles = '{32'sd0, 32'sd51472, -32'sd51471, 32'sd25000, -32'sd40000};  // pi/4 edges
        foreach (angles[i]) begin
            run_rotation(angles[i]);
        end
        repeat (8) begin
            run_rotation(take_bits(17) % 102943 - 51471);
        end
        finish_test("rotate_base", err0);
    endtask

    task automatic test_rotate_turns();
        cordic_pkg::data_t angles[6];
        cordic_pkg::data_t z;
        int                quad_exp;
        int                err0;
        err0   = errors;
        angles = '{32'sd65536, 32'sd196608, 32'sd294912, -32'sd131072,
                   32'sd1277952, -32'sd1277952};  // 1, 3, 4.5, -2, 19.5, -19.5 rad
        for (int i = 0; i < 22; i++) begin
            z = (i < 6) ? angles[i] : take_bits(22) % 2621441 - 1310720;  // +-20 rad
            quad_exp = quadrant_of($itor(z) / SCALE);
            run_rotation(z);
            check_flag(int'(i_cordic_top.quad) == quad_exp,
                       $sformatf("error at %0t: quadrant tag %0d, expected %0d", $time,
                                 i_cordic_top.quad, quad_exp));
        end
        finish_test("rotate_turns", err0);
    endtask

    task automatic test_vectoring();
        int err0;
        err0 = errors;
        run_vectoring(32'sd196608, 32'sd262144);   // (3, 4)
        run_vectoring(32'sd65536, -32'sd131072);   // (1, -2)
        repeat (10) begin
            run_vectoring(16384 + take_bits(18), take_bits(19) - 262144);
        end
        finish_test("vectoring", err0);
    endtask

    task automatic test_busy_enable();
        int err0;
        int extra;
        err0  = errors;
        extra = 0;
        start_op(cordic_pkg::op_vector, 32'sd196608, 32'sd262144, '0);
        repeat (4) @(negedge clk);
        enable = 1'b1;  // lands mid-iteration
        @(negedge clk);
        enable = 1'b0;
        wait_valid(latency);
        check_flag(latency + 5 == 19,
                   $sformatf("error at %0t: busy latency %0d, expected 19", $time, latency + 5));
        check_near("magnitude", x_out, 5.0 * SCALE);
        check_near("angle", z_out, $atan2(4.0, 3.0) * SCALE);
        repeat (30) begin
            @(negedge clk);
            extra += int'(valid);
        end
        check_flag(extra == 0, "the ignored enable still produced a second valid pulse");
        finish_test("busy_enable", err0);
    endtask

    initial begin
        rst    = 1'b1;
        enable = 1'b0;
        op     = cordic_pkg::op_rotate;
        x_in   = '0;
        y_in   = '0;
        z_in   = '0;
        lfsr   = 32'd31723;
        checks = 0;
        errors = 0;
        tests  = 0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        test_reset_idle();
        test_rotate_base();
        test_rotate_turns();
        test_vectoring();
        test_busy_enable();
        errors += i_cordic_top.i_sva.fail_count;  // timing assertions count as failed checks
        $display("tests: %0d, checks: %0d, failed checks: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== src.f ====
logic/cordic_pkg.sv
logic/cordic_ctrl.sv
logic/angle_reducer.sv
logic/cordic_iter.sv
logic/result_fix.sv
logic/cordic_top.sv
test/cordic_sva.sv
test/tb_cordic.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cordic
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early, see $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
